/* Makefile */
SOURCES := $(filter-out +%,$(shell cat filelist.f)) common/cache_defines.svh

.PHONY: all run clean

all: run

obj_dir/Vcache_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --top-module cache_tb -f filelist.f -o Vcache_tb

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb > sim.log 2>&1; cat sim.log
	grep -q '^All tests passed!$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* cache/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
  input  logic clock,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic hit,
  input  logic dirty,
  input  logic mem_ready,
  output logic ack,
  output logic sample,
  output logic fill,
  output logic write_word,
  output logic set_tag,
  output logic writeback_sel,
  output logic mem_valid,
  output logic mem_we,
  output logic ev_hit,
  output logic ev_miss,
  output logic ev_writeback
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_WRITEBACK,
    S_FILL
  } state_t;

  state_t state;
  state_t next_state;

  // set once a request has missed, so the repeated lookup is not counted again
  logic retry;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      retry <= 1'b0;
    end else if (ack) begin
      retry <= 1'b0;
    end else if (state == S_LOOKUP && !hit) begin
      retry <= 1'b1;
    end
  end

  always_comb begin
    next_state    = state;
    ack           = 1'b0;
    sample        = 1'b0;
    fill          = 1'b0;
    write_word    = 1'b0;
    set_tag       = 1'b0;
    writeback_sel = 1'b0;
    mem_valid     = 1'b0;
    mem_we        = 1'b0;
    ev_hit        = 1'b0;
    ev_miss       = 1'b0;
    ev_writeback  = 1'b0;

    case (state)
      S_IDLE: begin
        if (cyc && stb) begin
          sample     = 1'b1;
          next_state = S_LOOKUP;
        end
      end

      S_LOOKUP: begin
        if (hit) begin
          ack        = 1'b1;
          write_word = we;
          ev_hit     = !retry;
          next_state = S_IDLE;
        end else begin
          ev_miss    = !retry;
          next_state = dirty ? S_WRITEBACK : S_FILL;
        end
      end

      // push the victim line out before refilling
      S_WRITEBACK: begin
        mem_valid     = 1'b1;
        mem_we        = 1'b1;
        writeback_sel = 1'b1;
        if (mem_ready) begin
          ev_writeback = 1'b1;
          next_state   = S_FILL;
        end
      end

      S_FILL: begin
        mem_valid = 1'b1;
        if (mem_ready) begin
          fill       = 1'b1;
          set_tag    = 1'b1;
          next_state = S_LOOKUP;
        end
      end

      default: next_state = S_IDLE;
    endcase
  end

  a_ack_in_cycle: assert property (
    @(posedge clock) disable iff (reset) ack |-> (cyc && stb)
  );

  // memory request may not be withdrawn before it is accepted
  a_mem_hold: assert property (
    @(posedge clock) disable iff (reset) (mem_valid && !mem_ready) |=> mem_valid
  );

endmodule

/* cache/cache_path.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_path (
  input  logic                      clock,
  input  logic                      reset,
  input  cache_pkg::cache_addr_u    adr,
  input  logic [`CACHE_WORD_W-1:0]  dat_w,
  input  logic                      sample,
  input  logic                      fill,
  input  logic                      write_word,
  input  logic                      set_tag,
  input  logic                      writeback_sel,
  input  logic [`CACHE_LINE_W-1:0]  mem_rdata,
  output logic [`CACHE_WORD_W-1:0]  dat_r,
  output logic                      hit,
  output logic                      dirty,
  output cache_pkg::cache_addr_u    mem_addr,
  output logic [`CACHE_LINE_W-1:0]  mem_wdata
);
  import cache_pkg::*;

  // buffered request, every array below is indexed from it
  cache_addr_u               req_addr;
  logic [`CACHE_WORD_W-1:0]  req_data;

  logic [`CACHE_LINE_W-1:0]  data_mem [`CACHE_LINES];
  logic [`CACHE_TAG_W-1:0]   tag_mem  [`CACHE_LINES];
  logic [`CACHE_LINES-1:0]   valid_bits;
  logic [`CACHE_LINES-1:0]   dirty_bits;

  logic [`CACHE_INDEX_W-1:0] index;
  logic [`CACHE_WSEL_W-1:0]  wsel;
  logic [`CACHE_TAG_W-1:0]   req_tag;
  logic [`CACHE_LINE_W-1:0]  line;

  assign index   = req_addr.fields.index;
  assign wsel    = req_addr.fields.wsel;
  assign req_tag = req_addr.fields.tag;

  always_ff @(posedge clock) begin
    if (sample) begin
      req_addr <= adr;
      req_data <= dat_w;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (set_tag) begin
        valid_bits[index] <= 1'b1;
      end
      // a freshly filled line matches memory
      if (fill) begin
        dirty_bits[index] <= 1'b0;
      end else if (write_word) begin
        dirty_bits[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (set_tag) begin
      tag_mem[index] <= req_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      data_mem[index] <= mem_rdata;
    end else if (write_word) begin
      data_mem[index][wsel*`CACHE_WORD_W +: `CACHE_WORD_W] <= req_data;
    end
  end

  assign line  = data_mem[index];
  assign dat_r = line[wsel*`CACHE_WORD_W +: `CACHE_WORD_W];
  assign hit   = valid_bits[index] && (tag_mem[index] == req_tag);
  assign dirty = dirty_bits[index];

  // victim address uses the stored tag, a fill uses the request tag
  always_comb begin
    mem_addr.fields.tag      = writeback_sel ? tag_mem[index] : req_tag;
    mem_addr.fields.index    = index;
    mem_addr.fields.wsel     = '0;
    mem_addr.fields.byte_off = '0;
  end

  assign mem_wdata = line;

  // a line is either refilled from memory or patched by the processor, not both
  a_fill_write_excl: assert property (
    @(posedge clock) disable iff (reset) !(fill && write_word)
  );

endmodule

/* common/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// processor side byte address and data word
`define CACHE_ADDR_W   16
`define CACHE_WORD_W   32

// one cache line is four words
`define CACHE_LINE_W   128
`define CACHE_LINES    16

// address split: tag | index | word select | byte offset
`define CACHE_OFFSET_W 4
`define CACHE_WSEL_W   2
`define CACHE_INDEX_W  4
`define CACHE_TAG_W    8

`endif

/* common/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

  // address as the arrays see it
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]                   tag;
    logic [`CACHE_INDEX_W-1:0]                 index;
    logic [`CACHE_WSEL_W-1:0]                  wsel;
    logic [`CACHE_OFFSET_W-`CACHE_WSEL_W-1:0]  byte_off;
  } cache_fields_t;

  // the same 16 bits, either as a flat byte address or split into fields
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] word;
    cache_fields_t            fields;
  } cache_addr_u;

  // one block transfer towards the backing memory
  typedef struct packed {
    logic                     we;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_LINE_W-1:0] wdata;
  } mem_req_t;

  // statistics register map, word addressed
  typedef enum logic [1:0] {
    STAT_HITS       = 2'd0,
    STAT_MISSES     = 2'd1,
    STAT_WRITEBACKS = 2'd2
  } stat_sel_t;

endpackage

/* filelist.f */
+incdir+common
common/cache_pkg.sv
cache/cache_path.sv
cache/cache_control.sv
logic/cache_stats.sv
logic/cache_top.sv
verif/tb_clock.sv
verif/cache_checker.sv
verif/cache_tb.sv

/* logic/cache_stats.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_stats (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      st_cyc,
  input  logic                      st_stb,
  input  logic                      st_we,
  input  cache_pkg::stat_sel_t      st_adr,
  input  logic                      ev_hit,
  input  logic                      ev_miss,
  input  logic                      ev_writeback,
  output logic [`CACHE_WORD_W-1:0]  st_dat_r,
  output logic                      st_ack
);
  import cache_pkg::*;

  logic [`CACHE_WORD_W-1:0] hit_count;
  logic [`CACHE_WORD_W-1:0] miss_count;
  logic [`CACHE_WORD_W-1:0] wb_count;
  logic                     access;

  // counters stick at all ones instead of wrapping
  function automatic logic [`CACHE_WORD_W-1:0] bump(
    input logic [`CACHE_WORD_W-1:0] count,
    input logic                     ev
  );
    if (ev && count != '1) begin
      return count + 1'b1;
    end
    return count;
  endfunction

  // the !st_ack term keeps a held strobe from being acked twice
  assign access = st_cyc && st_stb && !st_ack;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      hit_count  <= '0;
      miss_count <= '0;
      wb_count   <= '0;
    end else if (access && st_we) begin
      hit_count  <= '0;
      miss_count <= '0;
      wb_count   <= '0;
    end else begin
      hit_count  <= bump(hit_count, ev_hit);
      miss_count <= bump(miss_count, ev_miss);
      wb_count   <= bump(wb_count, ev_writeback);
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      st_ack <= 1'b0;
    end else begin
      st_ack <= access;
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      case (st_adr)
        STAT_HITS:       st_dat_r <= hit_count;
        STAT_MISSES:     st_dat_r <= miss_count;
        STAT_WRITEBACKS: st_dat_r <= wb_count;
        default:         st_dat_r <= '0;
      endcase
    end
  end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_top (
  input  logic                      clock,
  input  logic                      reset,
  // processor port
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  cache_pkg::cache_addr_u    adr,
  input  logic [`CACHE_WORD_W-1:0]  dat_w,
  output logic [`CACHE_WORD_W-1:0]  dat_r,
  output logic                      ack,
  // statistics port
  input  logic                      st_cyc,
  input  logic                      st_stb,
  input  logic                      st_we,
  input  cache_pkg::stat_sel_t      st_adr,
  output logic [`CACHE_WORD_W-1:0]  st_dat_r,
  output logic                      st_ack,
  // backing memory
  output logic                      mem_valid,
  output cache_pkg::mem_req_t       mem_req,
  input  logic                      mem_ready,
  input  logic [`CACHE_LINE_W-1:0]  mem_rdata
);
  import cache_pkg::*;

  logic sample, fill, write_word, set_tag, writeback_sel;
  logic hit, dirty, mem_we;
  logic ev_hit, ev_miss, ev_writeback;

  cache_addr_u              mem_addr;
  logic [`CACHE_LINE_W-1:0] mem_wdata;

  cache_path u_path (
    .clock, .reset, .adr, .dat_w, .sample, .fill, .write_word, .set_tag,
    .writeback_sel, .mem_rdata, .dat_r, .hit, .dirty, .mem_addr, .mem_wdata
  );

  cache_control u_control (
    .clock, .reset, .cyc, .stb, .we, .hit, .dirty, .mem_ready, .ack, .sample,
    .fill, .write_word, .set_tag, .writeback_sel, .mem_valid, .mem_we,
    .ev_hit, .ev_miss, .ev_writeback
  );

  cache_stats u_stats (
    .clock, .reset, .st_cyc, .st_stb, .st_we, .st_adr, .ev_hit, .ev_miss,
    .ev_writeback, .st_dat_r, .st_ack
  );

  assign mem_req.we    = mem_we;
  assign mem_req.addr  = mem_addr.word;
  assign mem_req.wdata = mem_wdata;

endmodule

/* verif/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  cache_pkg::cache_addr_u adr,
  input  logic [31:0]            dat_w,
  input  logic [31:0]            dat_r,
  input  logic                   ack,
  input  logic                   st_cyc,
  input  logic                   st_stb,
  input  logic                   st_we,
  input  cache_pkg::stat_sel_t   st_adr,
  input  logic [31:0]            st_dat_r,
  input  logic                   st_ack,
  input  logic                   mem_valid,
  input  cache_pkg::mem_req_t    mem_req,
  input  logic                   mem_ready,
  output int                     value_errors,
  output int                     other_errors
);
  import cache_pkg::*;

  // flat view of the 1 KB window, always holding the latest data
  logic [31:0]  ref_mem [256];
  logic [7:0]   shadow_tag [16];
  logic [15:0]  shadow_valid;
  logic [15:0]  shadow_dirty;
  logic [31:0]  counts [3];
  cache_addr_u  req;
  logic [31:0]  req_data;
  logic [3:0]   idx;
  logic [15:0]  wb_addr;
  logic [127:0] wb_line;
  logic         req_we, active, pred_hit, fill_seen, wb_pending, after_reset;
  logic         st_write;
  stat_sel_t    st_sel;
  int           edges;
  int           k;

  function automatic logic [31:0] initial_word(input logic [7:0] word_idx);
    return {word_idx, ~word_idx, word_idx ^ 8'h5a, 8'hc3};
  endfunction

  function automatic logic [127:0] ref_line(input logic [15:0] addr);
    logic [7:0] base;
    base = {addr[9:4], 2'b00};
    return {ref_mem[base + 8'd3], ref_mem[base + 8'd2], ref_mem[base + 8'd1], ref_mem[base]};
  endfunction

  task automatic value_check(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report(input string what);
    other_errors++;
    $display("ERROR: %s", what);
  endtask

  // predict the outcome from the shadow tags and move the shadow on
  task automatic start_request();
    active = 1'b1;
    edges = 1;
    req = adr;
    req_we = we;
    req_data = dat_w;
    fill_seen = 1'b0;
    idx = adr.fields.index;
    pred_hit = shadow_valid[idx] && (shadow_tag[idx] == adr.fields.tag);
    if (pred_hit) begin
      counts[0]++;
    end else begin
      counts[1]++;
      if (shadow_valid[idx] && shadow_dirty[idx]) begin
        wb_pending = 1'b1;
        wb_addr = {shadow_tag[idx], idx, 4'h0};
        wb_line = ref_line(wb_addr);
        counts[2]++;
      end
      shadow_tag[idx] = adr.fields.tag;
      shadow_valid[idx] = 1'b1;
      shadow_dirty[idx] = 1'b0;
    end
    if (we) begin
      shadow_dirty[idx] = 1'b1;
    end
  endtask

  task automatic finish_request();
    if (pred_hit && edges != 2) begin
      value_check("hit_latency", 128'(2), 128'(edges));
    end
    if (!pred_hit && !fill_seen) begin
      report($sformatf("miss at %h acknowledged without a line fill", req.word));
    end
    if (wb_pending) begin
      report($sformatf("write-back of line %h never reached memory", wb_addr));
      wb_pending = 1'b0;
    end
    if (req_we) begin
      ref_mem[req.word[9:2]] = req_data;
    end else begin
      value_check($sformatf("read_data %h", req.word), 128'(ref_mem[req.word[9:2]]),
                  128'(dat_r));
    end
    active = 1'b0;
  endtask

  task automatic check_transfer();
    if (mem_req.we) begin
      if (!wb_pending) begin
        report($sformatf("unexpected write-back to %h", mem_req.addr));
      end else begin
        value_check("wb_addr", 128'(wb_addr), 128'(mem_req.addr));
        value_check("wb_data", wb_line, mem_req.wdata);
        wb_pending = 1'b0;
      end
    end else begin
      if (!active || pred_hit || wb_pending) begin
        report($sformatf("line fill from %h out of order", mem_req.addr));
      end
      value_check("fill_addr", 128'({req.word[15:4], 4'h0}), 128'(mem_req.addr));
      fill_seen = 1'b1;
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      for (k = 0; k < 256; k++) begin
        ref_mem[k] = initial_word(8'(k));
      end
      shadow_valid = '0;
      shadow_dirty = '0;
      counts[0] = '0;
      counts[1] = '0;
      counts[2] = '0;
      active = 1'b0;
      wb_pending = 1'b0;
      st_write = 1'b0;
      after_reset = 1'b1;
      value_errors = 0;
      other_errors = 0;
    end else begin
      if (after_reset && (ack || st_ack || mem_valid)) begin
        report("a handshake output is high right after reset");
      end
      after_reset = 1'b0;
      if (mem_valid && mem_ready) begin
        check_transfer();
      end
      if (active) begin
        edges++;
        if (ack) begin
          finish_request();
        end
      end else if (ack) begin
        report("ack without an open request");
      end else if (cyc && stb) begin
        start_request();
      end
      // statistics port, the counters only change on a clear
      if (st_ack) begin
        if (st_write) begin
          counts[0] = '0;
          counts[1] = '0;
          counts[2] = '0;
        end else begin
          value_check($sformatf("stat_count[%0d]", st_sel), 128'(counts[st_sel]),
                      128'(st_dat_r));
        end
      end else if (st_cyc && st_stb) begin
        st_write = st_we;
        st_sel = st_adr;
      end
    end
  end

endmodule

/* verif/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int NUM_OPS = 400;
  // a dirty miss with the slowest memory answer, plus the gap to the next request
  localparam int WORST_CYCLES = 30;
  localparam int WATCHDOG_NS = (NUM_OPS + 20) * WORST_CYCLES * 4 + 2000;

  logic         clock, reset;
  logic         cyc, stb, we, ack;
  cache_addr_u  adr;
  logic [31:0]  dat_w, dat_r;
  logic         st_cyc, st_stb, st_we, st_ack;
  stat_sel_t    st_adr;
  logic [31:0]  st_dat_r;
  logic         mem_valid, mem_ready;
  mem_req_t     mem_req;
  logic [127:0] mem_rdata;
  int           value_errors, other_errors;

  logic [31:0]  mem_words [256];
  logic [31:0]  stim_seed, mem_seed;
  int           mem_wait;
  int           k;

  tb_clock clock_gen (.clock, .reset);

  cache_top dut0 (
    .clock, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .st_cyc, .st_stb, .st_we, .st_adr, .st_dat_r, .st_ack,
    .mem_valid, .mem_req, .mem_ready, .mem_rdata
  );

  cache_checker check0 (
    .clock, .reset, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .st_cyc, .st_stb, .st_we, .st_adr, .st_dat_r, .st_ack,
    .mem_valid, .mem_req, .mem_ready, .value_errors, .other_errors
  );

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] initial_word(input logic [7:0] word_idx);
    return {word_idx, ~word_idx, word_idx ^ 8'h5a, 8'hc3};
  endfunction

  // called on a falling edge, returns on the falling edge after the ack
  task automatic cpu_access(input logic write, input logic [15:0] addr,
                            input logic [31:0] data);
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr.word = addr;
    dat_w = data;
    @(negedge clock);
    while (!ack) @(negedge clock);
    @(negedge clock);
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic random_access();
    logic [31:0] first;
    stim_seed = next_random(stim_seed);
    first = stim_seed;
    stim_seed = next_random(stim_seed);
    // 64 lines in a 1 KB window fold onto 16 indexes
    cpu_access(first[31], {6'b0, first[29:24], first[23:22], 2'b00},
               {first[15:0], stim_seed[31:16]});
  endtask

  task automatic stat_access(input logic write, input stat_sel_t sel);
    st_cyc = 1'b1;
    st_stb = 1'b1;
    st_we = write;
    st_adr = sel;
    @(negedge clock);
    while (!st_ack) @(negedge clock);
    st_cyc = 1'b0;
    st_stb = 1'b0;
    st_we = 1'b0;
  endtask

  task automatic read_counters();
    stat_access(1'b0, STAT_HITS);
    stat_access(1'b0, STAT_MISSES);
    stat_access(1'b0, STAT_WRITEBACKS);
  endtask

  task automatic serve_memory();
    logic [7:0] base;
    int         w;
    base = {mem_req.addr[9:4], 2'b00};
    if (mem_req.we) begin
      for (w = 0; w < 4; w++) begin
        mem_words[base + 8'(w)] = mem_req.wdata[w*32 +: 32];
      end
    end else begin
      mem_rdata = {mem_words[base + 8'd3], mem_words[base + 8'd2],
                   mem_words[base + 8'd1], mem_words[base]};
    end
    mem_ready = 1'b1;
  endtask

  // backing memory, answers each request after 1 to 6 cycles
  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    mem_seed = 32'd21;
    mem_wait = 0;
    for (k = 0; k < 256; k++) begin
      mem_words[k] = initial_word(8'(k));
    end
    forever begin
      @(negedge clock);
      if (mem_ready) begin
        mem_ready = 1'b0;
      end else if (mem_valid) begin
        if (mem_wait == 0) begin
          mem_seed = next_random(mem_seed);
          mem_wait = 1 + int'(mem_seed[31:16] % 16'd6);
        end
        mem_wait--;
        if (mem_wait == 0) begin
          serve_memory();
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    st_cyc = 1'b0;
    st_stb = 1'b0;
    st_we = 1'b0;
    st_adr = STAT_HITS;
    stim_seed = 32'd21;
    wait (!reset);
    @(negedge clock);
    read_counters();
    // write then read back, first on a miss and then on a hit
    cpu_access(1'b1, 16'h0040, 32'h1234_5678);
    cpu_access(1'b0, 16'h0040, 32'h0);
    // same index under another tag, so each dirty line evicts the other
    cpu_access(1'b1, 16'h0144, 32'hcafe_0144);
    cpu_access(1'b0, 16'h0040, 32'h0);
    cpu_access(1'b0, 16'h0144, 32'h0);
    repeat (NUM_OPS) random_access();
    read_counters();
    stat_access(1'b1, STAT_HITS);
    read_counters();
    repeat (4) @(negedge clock);
    $display("error counts: %0d value mismatches, %0d other errors",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // three rising edges in reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule
